// ==== common/nocLink.sv ====
interface nocLink;
    import nocPkg::*;

    logic valid;
    logic [coordWidth-1:0] dstX;
    logic [coordWidth-1:0] dstY;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] data;
    logic avail; // receiver buffer empty.

    modport sender
    (
        output valid, dstX, dstY, addr, data,
        input avail
    );

    modport receiver
    (
        input valid, dstX, dstY, addr, data,
        output avail
    );

endinterface

// ==== common/nocPkg.sv ====
package nocPkg;

    localparam int meshX = 3;
    localparam int meshY = 3;
    localparam int nodeCount = meshX * meshY;
    localparam int nodeIdWidth = 4; // ids 9..15 do not exist.
    localparam int coordWidth = 2;

    localparam int addrWidth = 4;
    localparam int memDepth = 1 << addrWidth;
    localparam int dataWidth = 32;

    // flit layout, data in the low bits and destination on top.
    localparam int flitDataLsb = 0;
    localparam int flitAddrLsb = flitDataLsb + dataWidth;
    localparam int flitDstYLsb = flitAddrLsb + addrWidth;
    localparam int flitDstXLsb = flitDstYLsb + coordWidth;
    localparam int flitWidth = flitDstXLsb + coordWidth;

    // north is row - 1, south is row + 1, east is column + 1.
    localparam int portLocal = 0;
    localparam int portNorth = 1;
    localparam int portSouth = 2;
    localparam int portEast = 3;
    localparam int portWest = 4;
    localparam int portCount = 5;
    localparam int portWidth = 3;

    localparam int inFlightWidth = 6; // one held command plus 45 router buffers.

    function automatic logic [coordWidth-1:0] nodeX(input logic [nodeIdWidth-1:0] id);
        nodeX = coordWidth'(id % meshX);
    endfunction

    function automatic logic [coordWidth-1:0] nodeY(input logic [nodeIdWidth-1:0] id);
        nodeY = coordWidth'(id / meshX);
    endfunction

endpackage

// ==== logic/nocWithNodes.sv ====
module nocWithNodes
(
    input  logic clk,
    input  logic rstN,

    input  logic cmdValid,
    input  logic [nocPkg::nodeIdWidth-1:0] cmdSrc,
    input  logic [nocPkg::nodeIdWidth-1:0] cmdDst,
    input  logic [nocPkg::addrWidth-1:0] cmdAddr,
    input  logic [nocPkg::dataWidth-1:0] cmdData,
    output logic cmdReady,

    output logic busy,

    input  logic [nocPkg::nodeIdWidth-1:0] peekId,
    input  logic [nocPkg::addrWidth-1:0] peekAddress,
    output logic [nocPkg::dataWidth-1:0] peekData
);
    import nocPkg::*;

    logic [nodeCount-1:0] written;
    logic [dataWidth-1:0] peekWords [nodeCount];

    nocLink injectLinks [nodeCount] ();

    for (genvar r = 0; r < meshY; r++)
    begin : rows
        for (genvar c = 0; c < meshX; c++)
        begin : columns
            localparam int id = r * meshX + c;

            nocLink inLinks [portCount] ();
            nocLink outLinks [portCount] ();

            meshRouter router
            (
                .clk(clk), .rstN(rstN),
                .nodeId(nodeIdWidth'(id)),
                .inLink(inLinks),
                .outLink(outLinks)
            );

            nodeMemory memory
            (
                .clk(clk), .rstN(rstN),
                .nodeId(nodeIdWidth'(id)),
                .ejectLink(outLinks[portLocal]),
                .written(written[id]),
                .peekAddress(peekAddress),
                .peekWord(peekWords[id])
            );

            // each node pulls its inputs from the neighbour facing that port.
            for (genvar p = 0; p < portCount; p++)
            begin : links
                localparam int nbrX = (p == portEast) ? c + 1 : (p == portWest) ? c - 1 : c;
                localparam int nbrY = (p == portSouth) ? r + 1 : (p == portNorth) ? r - 1 : r;
                localparam int backPort = (p == portNorth) ? portSouth :
                                          (p == portSouth) ? portNorth :
                                          (p == portEast) ? portWest : portEast;

                if (p == portLocal)
                begin : fromControl
                    assign inLinks[p].valid = injectLinks[id].valid;
                    assign inLinks[p].dstX = injectLinks[id].dstX;
                    assign inLinks[p].dstY = injectLinks[id].dstY;
                    assign inLinks[p].addr = injectLinks[id].addr;
                    assign inLinks[p].data = injectLinks[id].data;
                    assign injectLinks[id].avail = inLinks[p].avail;
                end
                else if (nbrX >= 0 && nbrX < meshX && nbrY >= 0 && nbrY < meshY)
                begin : fromNeighbour
                    assign inLinks[p].valid = rows[nbrY].columns[nbrX].outLinks[backPort].valid;
                    assign inLinks[p].dstX = rows[nbrY].columns[nbrX].outLinks[backPort].dstX;
                    assign inLinks[p].dstY = rows[nbrY].columns[nbrX].outLinks[backPort].dstY;
                    assign inLinks[p].addr = rows[nbrY].columns[nbrX].outLinks[backPort].addr;
                    assign inLinks[p].data = rows[nbrY].columns[nbrX].outLinks[backPort].data;
                    assign rows[nbrY].columns[nbrX].outLinks[backPort].avail = inLinks[p].avail;
                end
                else
                begin : meshBorder
                    assign inLinks[p].valid = 1'b0;
                    assign inLinks[p].dstX = '0;
                    assign inLinks[p].dstY = '0;
                    assign inLinks[p].addr = '0;
                    assign inLinks[p].data = '0;
                    assign outLinks[p].avail = 1'b0; // nothing leaves off the edge.
                end
            end
        end
    end

    trafficControl control
    (
        .clk(clk), .rstN(rstN),
        .cmdValid(cmdValid),
        .cmdSrc(cmdSrc),
        .cmdDst(cmdDst),
        .cmdAddr(cmdAddr),
        .cmdData(cmdData),
        .cmdReady(cmdReady),
        .injectLink(injectLinks),
        .written(written),
        .peekId(peekId),
        .peekWords(peekWords),
        .peekData(peekData),
        .busy(busy)
    );

endmodule

// ==== logic/nodeMemory.sv ====
module nodeMemory
(
    input  logic clk,
    input  logic rstN,
    input  logic [nocPkg::nodeIdWidth-1:0] nodeId,

    nocLink.receiver ejectLink,
    output logic written,

    input  logic [nocPkg::addrWidth-1:0] peekAddress,
    output logic [nocPkg::dataWidth-1:0] peekWord
);
    import nocPkg::*;

    logic [dataWidth-1:0] mem [memDepth];

    assign ejectLink.avail = 1'b1; // memory never stalls.
    assign written = ejectLink.valid;
    assign peekWord = mem[peekAddress];

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int a = 0; a < memDepth; a++)
                mem[a] <= '0;
        end
        else if (ejectLink.valid)
        begin
            mem[ejectLink.addr] <= ejectLink.data;
        end
    end

    // XY routing must only eject at the addressed node.
    ejectAtDest: assert property (@(posedge clk) disable iff (!rstN)
        ejectLink.valid |-> (ejectLink.dstX == nodeX(nodeId)) &&
                            (ejectLink.dstY == nodeY(nodeId)));

endmodule

// ==== logic/trafficControl.sv ====
module trafficControl
(
    input  logic clk,
    input  logic rstN,

    input  logic cmdValid,
    input  logic [nocPkg::nodeIdWidth-1:0] cmdSrc,
    input  logic [nocPkg::nodeIdWidth-1:0] cmdDst,
    input  logic [nocPkg::addrWidth-1:0] cmdAddr,
    input  logic [nocPkg::dataWidth-1:0] cmdData,
    output logic cmdReady,

    nocLink.sender injectLink [nocPkg::nodeCount],
    input  logic [nocPkg::nodeCount-1:0] written,

    input  logic [nocPkg::nodeIdWidth-1:0] peekId,
    input  logic [nocPkg::dataWidth-1:0] peekWords [nocPkg::nodeCount],
    output logic [nocPkg::dataWidth-1:0] peekData,
    output logic busy
);
    import nocPkg::*;

    logic held;
    logic [nodeIdWidth-1:0] heldSrc;
    logic [nodeIdWidth-1:0] heldDst;
    logic [addrWidth-1:0] heldAddr;
    logic [dataWidth-1:0] heldData;

    logic accept;
    logic sent;
    logic [nodeCount-1:0] injAvail;
    logic [nodeCount-1:0] injFire;
    logic [inFlightWidth-1:0] inFlight;
    logic [inFlightWidth-1:0] doneCount;

    assign cmdReady = !held;
    assign accept = cmdValid && cmdReady;

    // payload goes to every link, only the source node sees valid.
    for (genvar n = 0; n < nodeCount; n++)
    begin : inject
        assign injAvail[n] = injectLink[n].avail;
        assign injFire[n] = held && (heldSrc == n) && injAvail[n];
        assign injectLink[n].valid = injFire[n];
        assign injectLink[n].dstX = nodeX(heldDst);
        assign injectLink[n].dstY = nodeY(heldDst);
        assign injectLink[n].addr = heldAddr;
        assign injectLink[n].data = heldData;
    end

    assign sent = |injFire;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            held <= 1'b0;
        else if (accept)
            held <= 1'b1;
        else if (sent)
            held <= 1'b0; // source router took the flit.
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            heldSrc <= cmdSrc;
            heldDst <= cmdDst;
            heldAddr <= cmdAddr;
            heldData <= cmdData;
        end
    end

    // several memories can retire in the same cycle.
    always_comb
        doneCount = inFlightWidth'($countones(written));

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            inFlight <= '0;
        else
            inFlight <= inFlight + inFlightWidth'(accept) - doneCount;
    end

    assign busy = (inFlight != '0);

    always_comb
    begin
        if (peekId < nodeCount)
            peekData = peekWords[peekId];
        else
            peekData = '0; // no such node.
    end

    // every write pulse must belong to a command accepted earlier.
    noUnderflow: assert property (@(posedge clk) disable iff (!rstN)
        doneCount <= inFlight);

endmodule

// ==== mesh/meshRouter.sv ====
module meshRouter
(
    input  logic clk,
    input  logic rstN,
    input  logic [nocPkg::nodeIdWidth-1:0] nodeId,

    nocLink.receiver inLink [nocPkg::portCount],
    nocLink.sender outLink [nocPkg::portCount]
);
    import nocPkg::*;

    logic [coordWidth-1:0] myX;
    logic [coordWidth-1:0] myY;

    logic [portCount-1:0] inValid;
    logic [flitWidth-1:0] inFlit [portCount];
    logic [portCount-1:0] full;
    logic [flitWidth-1:0] bufFlit [portCount];
    logic [portWidth-1:0] route [portCount];
    logic [portCount-1:0] drain;

    logic [portCount-1:0] outAvail;
    logic [portCount-1:0] outValid;
    logic [portCount-1:0] grantValid;
    logic [portWidth-1:0] grantIdx [portCount];
    logic [portWidth-1:0] rrPtr [portCount];

    // x first, then y.
    function automatic logic [portWidth-1:0] xyRoute
    (
        input logic [coordWidth-1:0] dstX,
        input logic [coordWidth-1:0] dstY,
        input logic [coordWidth-1:0] hereX,
        input logic [coordWidth-1:0] hereY
    );
        if (dstX > hereX)
            return portWidth'(portEast);
        else if (dstX < hereX)
            return portWidth'(portWest);
        else if (dstY > hereY)
            return portWidth'(portSouth);
        else if (dstY < hereY)
            return portWidth'(portNorth);
        else
            return portWidth'(portLocal);
    endfunction

    assign myX = nodeX(nodeId);
    assign myY = nodeY(nodeId);

    for (genvar p = 0; p < portCount; p++)
    begin : ports
        assign inValid[p] = inLink[p].valid;
        assign inFlit[p] = {inLink[p].dstX, inLink[p].dstY, inLink[p].addr, inLink[p].data};
        assign inLink[p].avail = !full[p]; // registered, so no path from valid.

        assign outAvail[p] = outLink[p].avail;
        assign outLink[p].valid = outValid[p];
        assign outLink[p].dstX = bufFlit[grantIdx[p]][flitDstXLsb +: coordWidth];
        assign outLink[p].dstY = bufFlit[grantIdx[p]][flitDstYLsb +: coordWidth];
        assign outLink[p].addr = bufFlit[grantIdx[p]][flitAddrLsb +: addrWidth];
        assign outLink[p].data = bufFlit[grantIdx[p]][flitDataLsb +: dataWidth];

        // the upstream sender must wait for avail before raising valid.
        loadWhileFull: assert property (@(posedge clk) disable iff (!rstN)
            inValid[p] |-> !full[p]);
    end

    // a buffer frees on the edge it drains and refills one cycle later at the earliest.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            full <= '0;
        else
            full <= (full & ~drain) | (~full & inValid);
    end

    always_ff @(posedge clk)
    begin
        for (int p = 0; p < portCount; p++)
        begin
            if (inValid[p] && !full[p])
                bufFlit[p] <= inFlit[p];
        end
    end

    always_comb
    begin
        for (int p = 0; p < portCount; p++)
        begin
            route[p] = xyRoute(bufFlit[p][flitDstXLsb +: coordWidth],
                               bufFlit[p][flitDstYLsb +: coordWidth], myX, myY);
        end
    end

    // round robin per output, search starts after the last winner.
    always_comb
    begin
        int idx;
        grantValid = '0;
        drain = '0;
        outValid = '0;
        for (int o = 0; o < portCount; o++)
        begin
            grantIdx[o] = rrPtr[o];
            for (int k = 1; k <= portCount; k++)
            begin
                idx = int'(rrPtr[o]) + k;
                if (idx >= portCount)
                    idx = idx - portCount;
                if (!grantValid[o] && full[idx] && (route[idx] == o))
                begin
                    grantValid[o] = 1'b1;
                    grantIdx[o] = portWidth'(idx);
                end
            end
            outValid[o] = grantValid[o] && outAvail[o];
            if (outValid[o])
                drain[grantIdx[o]] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int o = 0; o < portCount; o++)
                rrPtr[o] <= portWidth'(portCount - 1); // port 0 goes first.
        end
        else
        begin
            for (int o = 0; o < portCount; o++)
            begin
                if (outValid[o])
                    rrPtr[o] <= grantIdx[o];
            end
        end
    end

endmodule

// ==== project.f ====
common/nocPkg.sv
common/nocLink.sv
mesh/meshRouter.sv
logic/nodeMemory.sv
logic/trafficControl.sv
logic/nocWithNodes.sv
verif/nocChecker.sv
verif/tbNocWithNodes.sv

// ==== verif/nocChecker.sv ====
module nocChecker
(
    input  logic clk,
    input  logic rstN,
    input  logic cmdValid,
    input  logic cmdReady,
    input  logic [nocPkg::nodeIdWidth-1:0] cmdDst,
    input  logic [nocPkg::addrWidth-1:0] cmdAddr,
    input  logic [nocPkg::dataWidth-1:0] cmdData,
    input  logic busy,
    input  logic [nocPkg::nodeIdWidth-1:0] peekId,
    input  logic [nocPkg::addrWidth-1:0] peekAddress,
    input  logic [nocPkg::dataWidth-1:0] peekData,
    output int errorCount
);
    import nocPkg::*;

    // one row per possible id, rows past the mesh stay zero.
    logic [dataWidth-1:0] model [1 << nodeIdWidth][memDepth];
    logic anyAccepted;
    logic [dataWidth-1:0] expected;

    initial
    begin
        errorCount = 0;
        anyAccepted = 1'b0;
        for (int n = 0; n < (1 << nodeIdWidth); n++)
            for (int a = 0; a < memDepth; a++)
                model[n][a] = '0;
    end

    always @(posedge clk)
    begin
        if (rstN && cmdValid && cmdReady)
        begin
            model[cmdDst][cmdAddr] <= cmdData; // a write lands here sooner or later.
            anyAccepted <= 1'b1;
        end
    end

    always @(negedge clk)
    begin
        if (rstN && !anyAccepted && (busy !== 1'b0 || cmdReady !== 1'b1))
        begin
            $display("ERR %0t: idle state after reset has busy=%b cmdReady=%b",
                     $time, busy, cmdReady);
            errorCount++;
        end
        // memories only settle once nothing is in flight.
        if (rstN && busy === 1'b0)
        begin
            expected = model[peekId][peekAddress];
            if (peekData !== expected)
            begin
                $display("ERR %0t: node %0d address %0d expected %h read %h",
                         $time, peekId, peekAddress, expected, peekData);
                errorCount++;
            end
        end
    end

endmodule

// ==== verif/tbNocWithNodes.sv ====
module tbNocWithNodes;
    import nocPkg::*;

    localparam int waitLimit = 500;

    typedef struct
    {
        int src;
        int dst;
        int addr;
        logic [dataWidth-1:0] data;
        bit useRandom;
        bit endsGroup;
    } stimEntry;

    logic clk;
    logic rstN;
    logic cmdValid;
    logic [nodeIdWidth-1:0] cmdSrc;
    logic [nodeIdWidth-1:0] cmdDst;
    logic [addrWidth-1:0] cmdAddr;
    logic [dataWidth-1:0] cmdData;
    logic cmdReady;
    logic busy;
    logic [nodeIdWidth-1:0] peekId;
    logic [addrWidth-1:0] peekAddress;
    logic [dataWidth-1:0] peekData;

    int checkErrors;
    int timeouts;
    logic [31:0] lfsrState;
    stimEntry stimTable [$];

    nocWithNodes dut0 (.*);

    nocChecker checker0 (.*, .errorCount(checkErrors));

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one new bit per step.
    function automatic logic nextRandomBit();
        logic feedback;
        feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] randomWord();
        logic [31:0] word;
        word = '0;
        for (int b = 0; b < 32; b++)
            word = {word[30:0], nextRandomBit()};
        return word;
    endfunction

    function automatic void addEntry
    (
        input int src,
        input int dst,
        input int addr,
        input logic [dataWidth-1:0] data,
        input bit useRandom,
        input bit endsGroup
    );
        stimTable.push_back('{src, dst, addr, data, useRandom, endsGroup});
    endfunction

    task automatic buildTable();
        // every pair once, the address is the source so nothing collides.
        for (int s = 0; s < nodeCount; s++)
            for (int d = 0; d < nodeCount; d++)
                addEntry(s, d, s, 0, 1'b1, s == nodeCount - 1 && d == nodeCount - 1);
        addEntry(4, 0, 12, 32'h1111_0000, 1'b0, 1'b0);
        addEntry(0, 8, 12, 32'h2222_0000, 1'b0, 1'b0);
        addEntry(8, 0, 13, 0, 1'b1, 1'b0);
        addEntry(2, 6, 12, 0, 1'b1, 1'b0);
        addEntry(6, 2, 12, 0, 1'b1, 1'b0);
        addEntry(1, 7, 13, 0, 1'b1, 1'b0);
        addEntry(7, 1, 13, 0, 1'b1, 1'b0);
        addEntry(3, 5, 14, 0, 1'b1, 1'b0);
        addEntry(5, 3, 14, 32'h3333_0000, 1'b0, 1'b1);
        // all sources converge on the centre node.
        for (int s = 0; s < nodeCount; s++)
            addEntry(s, 4, s + 7, 0, 1'b1, s == nodeCount - 1);
        addEntry(0, 8, 3, 32'haaaa_0001, 1'b0, 1'b0);
        addEntry(0, 8, 3, 32'haaaa_0002, 1'b0, 1'b0);
        addEntry(6, 2, 3, 32'h5555_0001, 1'b0, 1'b0);
        addEntry(0, 8, 3, 32'haaaa_0003, 1'b0, 1'b0);
        addEntry(6, 2, 3, 32'h5555_0002, 1'b0, 1'b1);
    endtask

    task automatic finishRun();
        $display("checker errors: %0d, timeouts: %0d", checkErrors, timeouts);
        if (checkErrors == 0 && timeouts == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic waitReady();
        int cycles;
        cycles = 0;
        while (cmdReady !== 1'b1 && cycles < waitLimit)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cmdReady !== 1'b1)
        begin
            $display("timeout: cmdReady stayed low for %0d cycles", waitLimit);
            timeouts++;
            finishRun();
        end
    endtask

    task automatic waitIdle();
        int cycles;
        cycles = 0;
        while (busy !== 1'b0 && cycles < waitLimit)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (busy !== 1'b0)
        begin
            $display("timeout: busy did not fall within %0d cycles", waitLimit);
            timeouts++;
            finishRun();
        end
    endtask

    task automatic sendCommand(input stimEntry e);
        waitReady();
        cmdValid = 1'b1;
        cmdSrc = nodeIdWidth'(e.src);
        cmdDst = nodeIdWidth'(e.dst);
        cmdAddr = addrWidth'(e.addr);
        if (e.useRandom)
            cmdData = randomWord();
        else
            cmdData = e.data;
        @(posedge clk); // ready was high, so this edge takes it.
        #1;
        cmdValid = 1'b0;
    endtask

    // ids 9 to 15 are swept too and must read zero.
    task automatic sweepPeek();
        for (int n = 0; n < (1 << nodeIdWidth); n++)
        begin
            for (int a = 0; a < memDepth; a++)
            begin
                peekId = nodeIdWidth'(n);
                peekAddress = addrWidth'(a);
                @(posedge clk);
                #1;
            end
        end
    endtask

    initial
    begin
        stimEntry e;
        rstN = 1'b0;
        cmdValid = 1'b0;
        cmdSrc = '0;
        cmdDst = '0;
        cmdAddr = '0;
        cmdData = '0;
        peekId = '0;
        peekAddress = '0;
        timeouts = 0;
        lfsrState = 32'hcb4754ac;
        buildTable();
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        sweepPeek();
        foreach (stimTable[i])
        begin
            e = stimTable[i];
            sendCommand(e);
            if (e.endsGroup)
            begin
                waitIdle();
                sweepPeek();
            end
        end
        finishRun();
    end

endmodule
